// File: Makefile
# Verilator build and run of the uart scope testbench, every variable can be set on the command line
VERILATOR ?= verilator
TOP       ?= tb_uart_scope
FILELIST  ?= uart_scope.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
FAIL_MSG  ?= RESULT: FAIL
PASS_MSG  ?= RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(VERILATOR), run $(TOP) and log to $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hw/cmd_parser.sv
// command frame decoder, turns a checked six byte frame into one register bus write
`timescale 1ns/1ps
`include "uart_scope_defs.svh"

module cmd_parser (
	input  logic                    Clk,
	input  logic                    Rst_n,
	input  logic [7:0]              rx_byte,
	input  logic                    rx_done,
	output uart_scope_pkg::reg_wr_t reg_wr
);

	uart_scope_pkg::parse_state_e state;
	logic        wr_q;
	logic [7:0]  addr_q;  // gathered fields, only meaningful with the strobe
	logic [15:0] data_q;

	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			state <= uart_scope_pkg::HDR0;
			wr_q  <= 1'b0;
		end else begin
			wr_q <= 1'b0;
			if (rx_done) begin
				case (state)
					uart_scope_pkg::HDR0:
						if (rx_byte == `UART_SCOPE_HDR0)
							state <= uart_scope_pkg::HDR1;
					uart_scope_pkg::HDR1:
						if (rx_byte == `UART_SCOPE_HDR1)
							state <= uart_scope_pkg::ADDR;
						else if (rx_byte != `UART_SCOPE_HDR0) // repeated 0x55 may still start a frame
							state <= uart_scope_pkg::HDR0;
					uart_scope_pkg::ADDR: state <= uart_scope_pkg::DHI;
					uart_scope_pkg::DHI:  state <= uart_scope_pkg::DLO;
					uart_scope_pkg::DLO:  state <= uart_scope_pkg::TAIL;
					default: begin
						wr_q  <= (rx_byte == `UART_SCOPE_TAIL); // bad trailer drops the whole frame
						state <= uart_scope_pkg::HDR0;
					end
				endcase
			end
		end
	end

	always_ff @(posedge Clk) begin
		if (rx_done) begin
			if (state == uart_scope_pkg::ADDR)
				addr_q <= rx_byte;
			if (state == uart_scope_pkg::DHI)
				data_q[15:8] <= rx_byte; // high byte is sent first
			if (state == uart_scope_pkg::DLO)
				data_q[7:0] <= rx_byte;
		end
	end

	assign reg_wr = '{wr: wr_q, addr: addr_q, data: data_q};

endmodule

// File: hw/dds_gen.sv
// phase accumulator waveform source, offers one saw or triangle sample at a time on valid/ready
`timescale 1ns/1ps
`include "uart_scope_defs.svh"

module dds_gen (
	input  logic                    Clk,
	input  logic                    Rst_n,
	input  logic [15:0]             freq_word,
	input  uart_scope_pkg::wave_e   wave,
	output uart_scope_pkg::sample_t sample,
	input  logic                    ready
);

	logic [15:0]                     phase;
	logic [`UART_SCOPE_SAMPLE_W-1:0] wave_val;

	// triangle folds the lower half phase back down once bit 15 is set
	assign wave_val = (wave == uart_scope_pkg::WAVE_TRI) ?
	                  (phase[15] ? ~phase[14:3] : phase[14:3]) : phase[15:4];

	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			phase        <= 16'd0;
			sample.valid <= 1'b1; // phase zero is ready right away
			sample.data  <= '0;   // both waveforms start at zero
		end else if (sample.valid) begin
			if (ready) begin
				phase        <= phase + freq_word;
				sample.valid <= 1'b0;
			end
		end else begin
			// data is captured once so a wave change cannot alter an offered sample
			sample.data  <= wave_val;
			sample.valid <= 1'b1;
		end
	end

	// an offered sample holds until the streamer takes it
	a_hold: assert property (@(posedge Clk) disable iff (!Rst_n)
		sample.valid && !ready |=> sample.valid && $stable(sample.data));

endmodule

// File: hw/sample_streamer.sv
// picks the sample source and hands the upper byte of each accepted sample to the transmitter
`timescale 1ns/1ps

module sample_streamer (
	input  logic                    Clk,
	input  logic                    Rst_n,
	input  logic                    run,
	input  uart_scope_pkg::src_e    src,
	input  uart_scope_pkg::sample_t dds_sample,
	output logic                    dds_ready,
	input  uart_scope_pkg::sample_t adc_sample,
	output logic                    adc_ready,
	input  logic                    tx_busy,
	output logic                    tx_start,
	output logic [7:0]              tx_byte
);

	uart_scope_pkg::sample_t sel;
	logic take;      // ready toward the selected source
	logic xfer;

	assign sel = (src == uart_scope_pkg::SRC_ADC) ? adc_sample : dds_sample;

	// tx_start covers the one cycle before tx_busy rises, so the streamer is idle otherwise
	assign take = run && !tx_start && !tx_busy;
	assign xfer = take && sel.valid;

	assign dds_ready = take && (src == uart_scope_pkg::SRC_DDS); // unselected source is held
	assign adc_ready = take && (src == uart_scope_pkg::SRC_ADC);

	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n)
			tx_start <= 1'b0;
		else
			tx_start <= xfer; // one cycle pulse after the handshake
	end

	always_ff @(posedge Clk) begin
		if (xfer)
			tx_byte <= sel.data[11:4]; // only the top 8 bits go over the wire
	end

endmodule

// File: hw/scope_regs.sv
// configuration registers, decode bus writes into the settings used by the streaming logic
`timescale 1ns/1ps
`include "uart_scope_defs.svh"

module scope_regs (
	input  logic                       Clk,
	input  logic                       Rst_n,
	input  uart_scope_pkg::reg_wr_t    reg_wr,
	output uart_scope_pkg::scope_cfg_t cfg
);

	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			cfg.run       <= 1'b0; // streaming stays off until the host asks
			cfg.src       <= uart_scope_pkg::SRC_DDS;
			cfg.baud_div  <= `UART_SCOPE_BAUD_RST;
			cfg.freq_word <= `UART_SCOPE_FREQ_RST;
			cfg.wave      <= uart_scope_pkg::WAVE_SAW;
			cfg.adc_chan  <= 3'd0;
		end else if (reg_wr.wr) begin
			case (reg_wr.addr)
				`UART_SCOPE_ADDR_CTRL: begin
					cfg.run <= reg_wr.data[0];
					cfg.src <= uart_scope_pkg::src_e'(reg_wr.data[1]);
				end
				`UART_SCOPE_ADDR_BAUD: cfg.baud_div  <= reg_wr.data; // used from the next byte
				`UART_SCOPE_ADDR_FREQ: cfg.freq_word <= reg_wr.data;
				`UART_SCOPE_ADDR_WAVE: cfg.wave <= uart_scope_pkg::wave_e'(reg_wr.data[0]);
				`UART_SCOPE_ADDR_CHAN: cfg.adc_chan  <= reg_wr.data[2:0];
				default: ; // other addresses have no register behind them
			endcase
		end
	end

endmodule

// File: hw/uart_rx.sv
// uart byte receiver, samples each bit in its middle at the divisor latched at the start edge
`timescale 1ns/1ps

module uart_rx (
	input  logic        Clk,
	input  logic        Rst_n,
	input  logic        rx,
	input  logic [15:0] baud_div,
	output logic [7:0]  rx_byte,
	output logic        rx_done
);

	uart_scope_pkg::rx_state_e state;
	logic [1:0]  rx_sync;  // two flop synchronizer, line idles high
	logic        rx_prev;
	logic        rx_fall;
	logic [15:0] div_q;    // held for the whole byte so a baud change waits for the next one
	logic [15:0] cnt;
	logic [2:0]  bit_idx;
	logic [7:0]  shreg;
	logic        sample;

	assign rx_fall = rx_prev && !rx_sync[1];

	// start bit is checked at half a bit, every later bit one full bit after that
	assign sample = (state == uart_scope_pkg::RX_START) ? (cnt == (div_q >> 1) - 16'd1)
	                                                    : (cnt == div_q - 16'd1);

	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			rx_sync <= 2'b11;
			rx_prev <= 1'b1;
		end else begin
			rx_sync <= {rx_sync[0], rx};
			rx_prev <= rx_sync[1];
		end
	end

	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			state   <= uart_scope_pkg::RX_IDLE;
			cnt     <= 16'd0;
			bit_idx <= 3'd0;
			rx_done <= 1'b0;
		end else begin
			rx_done <= 1'b0; // pulse only
			cnt     <= sample ? 16'd0 : cnt + 16'd1;
			case (state)
				uart_scope_pkg::RX_IDLE: begin
					cnt <= 16'd0;
					if (rx_fall)
						state <= uart_scope_pkg::RX_START;
				end
				uart_scope_pkg::RX_START: if (sample) begin
					bit_idx <= 3'd0;
					// a high line at mid start bit was a glitch
					state   <= rx_sync[1] ? uart_scope_pkg::RX_IDLE : uart_scope_pkg::RX_DATA;
				end
				uart_scope_pkg::RX_DATA: if (sample) begin
					bit_idx <= bit_idx + 3'd1;
					if (bit_idx == 3'd7)
						state <= uart_scope_pkg::RX_STOP;
				end
				default: if (sample) begin
					rx_done <= rx_sync[1]; // low stop bit drops the byte
					state   <= uart_scope_pkg::RX_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge Clk) begin
		if (state == uart_scope_pkg::RX_IDLE && rx_fall)
			div_q <= baud_div;
		if (state == uart_scope_pkg::RX_DATA && sample)
			shreg <= {rx_sync[1], shreg[7:1]}; // lsb arrives first
	end

	assign rx_byte = shreg;

	// each received byte gives exactly one isolated done pulse
	a_done_single: assert property (@(posedge Clk) disable iff (!Rst_n) rx_done |=> !rx_done);

endmodule

// File: hw/uart_scope.sv
// top level of the serial scope: uart command path, config registers, sources and byte stream
`timescale 1ns/1ps

module uart_scope (
	input  logic        Clk,
	input  logic        Rst_n,
	input  logic        rs232_rx,
	output logic        rs232_tx,
	input  logic [11:0] adc_data,
	input  logic        adc_valid,
	output logic        adc_ready,
	output logic [2:0]  adc_chan
);

	logic [7:0]                 rx_byte;
	logic                       rx_done;
	uart_scope_pkg::reg_wr_t    reg_wr;
	uart_scope_pkg::scope_cfg_t cfg;
	uart_scope_pkg::sample_t    dds_sample;
	uart_scope_pkg::sample_t    adc_sample;
	logic                       dds_ready;
	logic                       tx_start;
	logic [7:0]                 tx_byte;
	logic                       tx_busy;

	// external adc port enters as a regular sample
	assign adc_sample = '{valid: adc_valid, data: adc_data};
	assign adc_chan   = cfg.adc_chan;

	uart_rx u_rx (.Clk, .Rst_n, .rx(rs232_rx), .baud_div(cfg.baud_div), .rx_byte, .rx_done);

	cmd_parser u_parser (.Clk, .Rst_n, .rx_byte, .rx_done, .reg_wr);

	scope_regs u_regs (.Clk, .Rst_n, .reg_wr, .cfg);

	dds_gen u_dds (
		.Clk, .Rst_n,
		.freq_word(cfg.freq_word), .wave(cfg.wave),
		.sample(dds_sample), .ready(dds_ready)
	);

	sample_streamer u_stream (
		.Clk, .Rst_n,
		.run(cfg.run), .src(cfg.src),
		.dds_sample, .dds_ready, .adc_sample, .adc_ready,
		.tx_busy, .tx_start, .tx_byte
	);

	uart_tx u_tx (
		.Clk, .Rst_n, .baud_div(cfg.baud_div),
		.tx_start, .tx_byte, .tx(rs232_tx), .tx_busy
	);

endmodule

// File: hw/uart_scope_pkg.sv
// shared types of the uart scope, referenced by scoped name from every RTL block
`include "uart_scope_defs.svh"

package uart_scope_pkg;

	// single cycle write strobe bus from the parser to the config block
	typedef struct packed {
		logic        wr;   // one cycle write strobe
		logic [7:0]  addr;
		logic [15:0] data;
	} reg_wr_t;

	typedef enum logic {WAVE_SAW, WAVE_TRI} wave_e;

	typedef enum logic {SRC_DDS, SRC_ADC} src_e;

	typedef struct packed {
		logic        run;       // streaming enable
		src_e        src;
		logic [15:0] baud_div;  // cycles per bit for both uart directions
		logic [15:0] freq_word; // phase step per dds sample
		wave_e       wave;
		logic [2:0]  adc_chan;
	} scope_cfg_t;

	// a sample travels with its valid bit, ready comes back separately
	typedef struct packed {
		logic                           valid;
		logic [`UART_SCOPE_SAMPLE_W-1:0] data;
	} sample_t;

	typedef enum logic [2:0] {HDR0, HDR1, ADDR, DHI, DLO, TAIL} parse_state_e;

	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;
	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

endpackage

// File: hw/uart_tx.sv
// uart byte transmitter, sends start, 8 data bits lsb first and stop, busy for the whole frame
`timescale 1ns/1ps

module uart_tx (
	input  logic        Clk,
	input  logic        Rst_n,
	input  logic [15:0] baud_div,
	input  logic        tx_start,
	input  logic [7:0]  tx_byte,
	output logic        tx,
	output logic        tx_busy
);

	uart_scope_pkg::tx_state_e state;
	logic [15:0] div_q;   // divisor of the byte in flight
	logic [15:0] cnt;
	logic [2:0]  bit_idx;
	logic [7:0]  shreg;
	logic        load;
	logic        bit_end;
	logic        shift;

	assign load    = (state == uart_scope_pkg::TX_IDLE) && tx_start;
	assign bit_end = (cnt == div_q - 16'd1);
	assign shift   = bit_end && (state == uart_scope_pkg::TX_START ||
	                             state == uart_scope_pkg::TX_DATA);

	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			state   <= uart_scope_pkg::TX_IDLE;
			cnt     <= 16'd0;
			bit_idx <= 3'd0;
			tx      <= 1'b1; // line idles high
		end else begin
			cnt <= (bit_end || state == uart_scope_pkg::TX_IDLE) ? 16'd0 : cnt + 16'd1;
			case (state)
				uart_scope_pkg::TX_IDLE: if (tx_start) begin
					tx    <= 1'b0; // start bit
					state <= uart_scope_pkg::TX_START;
				end
				uart_scope_pkg::TX_START: if (bit_end) begin
					tx      <= shreg[0];
					bit_idx <= 3'd0;
					state   <= uart_scope_pkg::TX_DATA;
				end
				uart_scope_pkg::TX_DATA: if (bit_end) begin
					tx      <= shreg[0]; // ones shifted in make this the stop level after bit 7
					bit_idx <= bit_idx + 3'd1;
					if (bit_idx == 3'd7)
						state <= uart_scope_pkg::TX_STOP;
				end
				default: if (bit_end)
					state <= uart_scope_pkg::TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge Clk) begin
		if (load) begin
			shreg <= tx_byte;
			div_q <= baud_div;
		end else if (shift) begin
			shreg <= {1'b1, shreg[7:1]};
		end
	end

	assign tx_busy = (state != uart_scope_pkg::TX_IDLE);

	// the streamer must wait for the frame to finish before the next byte
	a_no_start_busy: assert property (@(posedge Clk) disable iff (!Rst_n) tx_start |-> !tx_busy);

endmodule

// File: include/uart_scope_defs.svh
// constants shared by the uart scope RTL: frame bytes, register map, reset values and widths
`ifndef UART_SCOPE_DEFS_SVH
`define UART_SCOPE_DEFS_SVH

// command frame is HDR0 HDR1 ADDR DATA_HI DATA_LO TAIL
`define UART_SCOPE_HDR0 8'h55
`define UART_SCOPE_HDR1 8'hA5
`define UART_SCOPE_TAIL 8'hF0

// register addresses on the internal write bus
`define UART_SCOPE_ADDR_CTRL 8'h00 // bit 0 run, bit 1 source
`define UART_SCOPE_ADDR_BAUD 8'h01 // clock cycles per uart bit
`define UART_SCOPE_ADDR_FREQ 8'h02 // dds phase step
`define UART_SCOPE_ADDR_WAVE 8'h03 // bit 0 selects triangle
`define UART_SCOPE_ADDR_CHAN 8'h04 // adc channel in bits 2:0

`define UART_SCOPE_BAUD_RST 16'd16 // short bit time keeps simulation quick
`define UART_SCOPE_FREQ_RST 16'h0100

`define UART_SCOPE_SAMPLE_W 12

`endif

// File: sim/scope_checker.sv
// testbench checker that decodes the scope uart output and compares each byte with reference models
`timescale 1ns/1ps
`include "uart_scope_defs.svh"

module scope_checker (
	input  logic        Clk,
	input  logic        Rst_n,
	input  logic        rs232_tx,
	input  logic [11:0] adc_data,
	input  logic        adc_valid,
	input  logic        adc_ready,
	input  logic [2:0]  adc_chan,
	input  logic [3:0]  test_id,
	input  logic        test_end,   // one cycle pulse that closes the current test
	input  logic        wr_evt,     // a good frame carrying wr_addr and wr_data was sent
	input  logic [7:0]  wr_addr,
	input  logic [15:0] wr_data,
	input  logic        quiet,      // run is off and any new start bit is an error
	input  logic        finish_req,
	output int          test_bytes,
	output int          errors,
	output int          tests_failed
);

	localparam int MIN_STREAM = 16; // bytes every streaming test must deliver

	logic [15:0] sh_baud;
	logic [15:0] sh_freq;
	logic [15:0] phase;     // phase of the sample the dds offers next
	logic        sh_src;
	logic        sh_wave;
	logic        pend_wave; // wave the dds used when it captured its offered sample
	logic [2:0]  sh_chan;
	logic [7:0]  adc_q[$];  // upper bytes of accepted adc samples in the order they were taken
	logic [7:0]  shreg;
	logic        busy;
	logic        line_prev;
	int          cnt;
	int          bit_n;
	int          div;
	int          test_errs;
	int          tests_run;
	int          total_bytes;

	// the saw is the phase scaled down to 12 bits
	// the triangle climbs over the first half of the phase circle and mirrors back down after it
	function automatic logic [11:0] dds_ref(input logic [15:0] ph, input logic is_tri);
		logic [15:0] ramp;
		if (!is_tri)
			return ph[15:4];
		ramp = (ph < 16'h8000) ? ph : 16'hFFFF - ph; // distance from the nearer end of the circle
		return ramp[14:3];
	endfunction

	function automatic logic [7:0] adc_ref(input logic [11:0] s);
		return s[11:4]; // only the top byte goes over the wire
	endfunction

	function automatic string test_name(input logic [3:0] id);
		case (id)
			4'd1: return "register write and channel";
			4'd2: return "rejected frame";
			4'd3: return "dds sawtooth stream";
			4'd4: return "triangle waveform";
			4'd5: return "adc source";
			4'd6: return "stop and baud change";
			default: return "outside any test";
		endcase
	endfunction

	task automatic report_fail(input string msg);
		$display("ERROR in %s: %s", test_name(test_id), msg);
		test_errs++;
		errors++;
	endtask

	task automatic value_check(input logic [7:0] expected, input logic [7:0] actual);
		if (expected !== actual) begin
			$display("CHECK FAILED %s: expected 0x%h actual 0x%h", test_name(test_id),
			         expected, actual);
			test_errs++;
			errors++;
		end
	endtask

	task automatic check_byte(input logic [7:0] b);
		logic [11:0] ref_s;
		test_bytes++;
		total_bytes++;
		if (sh_src) begin
			if (adc_q.size() == 0)
				report_fail($sformatf("byte 0x%h was sent without an accepted adc sample", b));
			else
				value_check(adc_q.pop_front(), b);
		end else begin
			ref_s = dds_ref(phase, pend_wave);
			value_check(ref_s[11:4], b);
			phase     = phase + sh_freq; // the dds stepped when this sample left
			pend_wave = sh_wave;         // and captured its next sample right after
		end
	endtask

	task automatic close_test();
		value_check({5'd0, sh_chan}, {5'd0, adc_chan}); // channel output follows the shadow
		if (test_id >= 4'd3 && test_bytes < MIN_STREAM)
			report_fail($sformatf("only %0d bytes were streamed", test_bytes));
		$display("test %0d %s: %s, %0d bytes, %0d errors", test_id, test_name(test_id),
		         (test_errs == 0) ? "ok" : "failed", test_bytes, test_errs);
		tests_run++;
		if (test_errs != 0)
			tests_failed++;
		test_errs  = 0;
		test_bytes = 0;
	endtask

	// everything is sampled on the falling edge where dut outputs are settled
	always @(negedge Clk) begin
		if (!Rst_n) begin
			sh_baud      = `UART_SCOPE_BAUD_RST;
			sh_freq      = `UART_SCOPE_FREQ_RST;
			phase        = 16'd0;
			sh_src       = 1'b0;
			sh_wave      = 1'b0;
			pend_wave    = 1'b0; // the reset sample is phase zero on the saw
			sh_chan      = 3'd0;
			busy         = 1'b0;
			line_prev    = 1'b1;
			test_bytes   = 0;
			errors       = 0;
			tests_failed = 0;
			test_errs    = 0;
			tests_run    = 0;
			total_bytes  = 0;
			adc_q.delete();
		end else begin
			if (wr_evt) begin
				case (wr_addr)
					`UART_SCOPE_ADDR_CTRL: sh_src  = wr_data[1];
					`UART_SCOPE_ADDR_BAUD: sh_baud = wr_data;
					`UART_SCOPE_ADDR_FREQ: sh_freq = wr_data;
					`UART_SCOPE_ADDR_WAVE: sh_wave = wr_data[0];
					`UART_SCOPE_ADDR_CHAN: sh_chan = wr_data[2:0];
					default: ;
				endcase
			end
			if (adc_valid && adc_ready)
				adc_q.push_back(adc_ref(adc_data)); // transfer happens on the coming edge
			if (!busy) begin
				if (line_prev && !rs232_tx) begin
					busy  = 1'b1;
					cnt   = 0;
					bit_n = 0;
					div   = int'(sh_baud); // divisor stays fixed for the whole byte
					if (quiet)
						report_fail("start bit on rs232_tx while streaming is stopped");
				end
			end else begin
				cnt++;
				if (bit_n == 0 && cnt == div / 2) begin
					if (rs232_tx)
						report_fail("start bit was high at its middle");
					bit_n = 1;
					cnt   = 0;
				end else if (cnt == div) begin
					cnt = 0;
					if (bit_n == 9) begin
						if (!rs232_tx)
							report_fail("stop bit was low");
						busy = 1'b0;
						check_byte(shreg);
					end else begin
						shreg = {rs232_tx, shreg[7:1]}; // lsb comes first
						bit_n++;
					end
				end
			end
			line_prev = rs232_tx;
			if (test_end)
				close_test();
			if (finish_req)
				$display("tests %0d, failed %0d, bytes checked %0d, errors %0d",
				         tests_run, tests_failed, total_bytes, errors);
		end
	end

endmodule

// File: sim/tb_uart_scope.sv
// testbench top that drives command frames and adc samples into the scope and runs the six tests
`timescale 1ns/1ps
`include "uart_scope_defs.svh"

module tb_uart_scope;

	localparam int BYTES_PER_TEST = 20;
	localparam int BITS_PER_BYTE  = 10;
	localparam int MAX_DIV        = 24;
	localparam int NUM_TESTS      = 6;
	localparam int CYCLE_LIMIT    = BYTES_PER_TEST * BITS_PER_BYTE * MAX_DIV * NUM_TESTS + 20000;

	logic        Clk;
	logic        Rst_n;
	logic        rs232_rx;
	logic        rs232_tx;
	logic [11:0] adc_data;
	logic [11:0] adc_next; // next value the adc driver offers
	logic        adc_valid;
	logic        adc_ready;
	logic [2:0]  adc_chan;
	logic [3:0]  test_id;
	logic        test_end;
	logic        wr_evt;
	logic [7:0]  wr_addr;
	logic [15:0] wr_data;
	logic        quiet;
	logic        finish_req;
	logic [31:0] rng;
	int          tb_baud;  // bit time the host side uses for its frames
	int          test_bytes;
	int          errors;
	int          tests_failed;
	int          cycle_cnt;

	uart_scope u_dut (
		.Clk, .Rst_n, .rs232_rx, .rs232_tx,
		.adc_data, .adc_valid, .adc_ready, .adc_chan
	);

	scope_checker u_chk (.*);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		return s ^ (s << 5);
	endfunction

	task automatic next_cycle();
		@(posedge Clk);
		#1; // inputs change just after the edge
	endtask

	task automatic send_byte(input logic [7:0] b);
		logic [7:0] sh;
		sh       = b;
		rs232_rx = 1'b0; // start bit
		repeat (tb_baud) next_cycle();
		repeat (8) begin
			rs232_rx = sh[0];
			sh       = sh >> 1;
			repeat (tb_baud) next_cycle();
		end
		rs232_rx = 1'b1; // stop bit leaves the line idling high
		repeat (tb_baud) next_cycle();
	endtask

	task automatic send_bytes(input logic [7:0] addr, input logic [15:0] data,
	                          input logic [7:0] tail);
		send_byte(`UART_SCOPE_HDR0);
		send_byte(`UART_SCOPE_HDR1);
		send_byte(addr);
		send_byte(data[15:8]);
		send_byte(data[7:0]);
		send_byte(tail);
	endtask

	// a good frame is also posted to the checker shadow
	task automatic send_frame(input logic [7:0] addr, input logic [15:0] data);
		send_bytes(addr, data, `UART_SCOPE_TAIL);
		wr_addr = addr;
		wr_data = data;
		wr_evt  = 1'b1;
		if (addr == `UART_SCOPE_ADDR_BAUD)
			tb_baud = int'(data);
		next_cycle();
		wr_evt = 1'b0;
	endtask

	task automatic send_bad_frame(input logic [7:0] addr, input logic [15:0] data);
		send_bytes(addr, data, `UART_SCOPE_TAIL ^ 8'hFF);
	endtask

	// the line must stay high for a whole frame plus a bit before the last byte counts as done
	task automatic wait_line_idle();
		int high_cnt;
		high_cnt = 0;
		while (high_cnt < 11 * tb_baud) begin
			@(negedge Clk);
			high_cnt = rs232_tx ? high_cnt + 1 : 0;
		end
		next_cycle();
	endtask

	task automatic start_stream(input logic src);
		quiet = 1'b0;
		send_frame(`UART_SCOPE_ADDR_CTRL, {14'd0, src, 1'b1});
	endtask

	task automatic stop_stream(input logic src);
		send_frame(`UART_SCOPE_ADDR_CTRL, {14'd0, src, 1'b0});
		quiet = 1'b1; // only the byte already on the line may still finish
		wait_line_idle();
	endtask

	task automatic wait_bytes(input int n);
		while (test_bytes < n)
			next_cycle();
	endtask

	task automatic end_test(input logic [3:0] next_id);
		test_end = 1'b1;
		next_cycle();
		test_end = 1'b0;
		test_id  = next_id;
		next_cycle();
	endtask

	initial begin
		Clk = 1'b0;
		forever #5 Clk = ~Clk;
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < CYCLE_LIMIT) begin
			@(posedge Clk);
			cycle_cnt++;
		end
		$display("timeout: the tests did not finish within %0d clock cycles", CYCLE_LIMIT);
		$display("RESULT: FAIL");
		$finish;
	end

	// adc port with incrementing samples and random idle gaps where each sample holds until taken
	initial begin : adc_driver
		int   gap;
		logic taken;
		wait (Rst_n === 1'b1);
		next_cycle();
		forever begin
			rng       = xorshift32(rng);
			gap       = int'(rng % 32'd4);
			adc_valid = 1'b0;
			repeat (gap) next_cycle();
			adc_valid = 1'b1;
			adc_data  = adc_next;
			taken     = 1'b0;
			while (!taken) begin
				@(negedge Clk);
				taken = adc_ready; // with valid already high a ready means a transfer
			end
			next_cycle();
			adc_next = adc_next + 12'h013;
		end
	end

	initial begin
		Rst_n      = 1'b0;
		rs232_rx   = 1'b1;
		adc_data   = '0;
		adc_valid  = 1'b0;
		adc_next   = 12'h005;
		test_id    = 4'd1;
		test_end   = 1'b0;
		wr_evt     = 1'b0;
		wr_addr    = '0;
		wr_data    = '0;
		quiet      = 1'b1; // run is off after reset
		finish_req = 1'b0;
		rng        = 32'h82a;
		tb_baud    = int'(`UART_SCOPE_BAUD_RST);
		repeat (3) @(posedge Clk);
		#1 Rst_n = 1'b1;
		next_cycle();

		send_frame(`UART_SCOPE_ADDR_CHAN, 16'd5);
		end_test(4'd2);

		send_bad_frame(`UART_SCOPE_ADDR_CHAN, 16'd2); // channel must stay at 5
		end_test(4'd3);

		send_frame(`UART_SCOPE_ADDR_FREQ, 16'h0340);
		send_frame(`UART_SCOPE_ADDR_WAVE, 16'd0);
		start_stream(1'b0);
		wait_bytes(16);
		stop_stream(1'b0);
		end_test(4'd4);

		send_frame(`UART_SCOPE_ADDR_WAVE, 16'd1); // the held sample keeps the saw shape
		start_stream(1'b0);
		wait_bytes(16);
		stop_stream(1'b0);
		end_test(4'd5);

		start_stream(1'b1);
		wait_bytes(16);
		stop_stream(1'b1);
		end_test(4'd6);

		send_frame(`UART_SCOPE_ADDR_BAUD, 16'd24); // sent while quiet guards the stopped line
		start_stream(1'b1);
		wait_bytes(16);
		stop_stream(1'b1);
		end_test(4'd7);

		finish_req = 1'b1;
		next_cycle();
		finish_req = 1'b0;
		next_cycle();
		if (errors == 0 && tests_failed == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: uart_scope.f
+incdir+include
hw/uart_scope_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/cmd_parser.sv
hw/scope_regs.sv
hw/dds_gen.sv
hw/sample_streamer.sv
hw/uart_scope.sv
sim/scope_checker.sv
sim/tb_uart_scope.sv
